// ==== source/rob_pkg.sv ====
package rob_pkg;

    // function units reporting completion
    // 0 alu0, 1 alu1, 2 mdu, 3 lsu
    parameter int NUM_FU = 4;

    // capability masks with one bit per unit
    parameter logic [NUM_FU-1:0] FU_CAN_BRANCH = 4'b0011;
    parameter logic [NUM_FU-1:0] FU_CAN_EXC    = 4'b1011;

    // id is {row, lane} and sized for 64 rows
    parameter int ID_W_MAX = 7;

    // exception cause
    typedef enum logic [3:0] {
        EXC_NONE = 4'd0,
        EXC_ADEL = 4'd1,
        EXC_ADES = 4'd2,
        EXC_OV   = 4'd3,
        EXC_SYS  = 4'd4,
        EXC_BP   = 4'd5,
        EXC_RI   = 4'd6
    } exc_code_t;

    // one reorder buffer entry
    typedef struct packed {
        logic                valid;
        logic                busy;
        logic                is_ds;
        logic [31:0]         pc;
        logic [5:0]          dest_reg;
        logic                branch_taken;
        logic [31:0]         branch_addr;
        logic                cause_exc;
        exc_code_t           exception;
        logic [ID_W_MAX-1:0] id;
        logic                committed;
    } uop_t;

    // completion report from one unit
    typedef struct packed {
        logic                finish;
        logic [ID_W_MAX-1:0] id;
        logic                set_branch;
        logic                branch_taken;
        logic [31:0]         branch_addr;
        logic                set_exc;
        exc_code_t           exc_code;
    } fu_report_t;

endpackage

// ==== source/rob_ifs.sv ====
`timescale 1ns/1ns

// dispatch write toward both lane banks
interface rob_write_if import rob_pkg::*; #(
    parameter int ROB_DEPTH = 16
);

    localparam int PTR_W = $clog2(ROB_DEPTH);

    logic             we;
    logic [PTR_W-1:0] index;
    uop_t             uop0;
    uop_t             uop1;

    modport ctrl (
        output we,
        output index,
        output uop0,
        output uop1
    );

    modport bank (
        input we,
        input index,
        input uop0,
        input uop1
    );

endinterface

// completion updates for one lane with one slot per unit
interface rob_update_if import rob_pkg::*; #(
    parameter int ROB_DEPTH = 16
);

    localparam int PTR_W = $clog2(ROB_DEPTH);

    logic [NUM_FU-1:0] en;
    logic [PTR_W-1:0]  index  [NUM_FU];
    fu_report_t        report [NUM_FU];

    modport router (output en, output index, output report);

    modport bank (input en, input index, input report);

endinterface

// ==== source/rob_ctrl.sv ====
`timescale 1ns/1ns

module rob_ctrl import rob_pkg::*; #(
    parameter int ROB_DEPTH = 16
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         flush,

    input  logic                         dispatch_valid,
    output logic                         dispatch_ready,
    output logic [$clog2(ROB_DEPTH)-1:0] rob_id,
    output logic                         rob_empty,
    output logic                         rob_full,
    input  uop_t                         dispatch_uop0,
    input  uop_t                         dispatch_uop1,

    input  logic                         commit_ready,
    output logic                         commit_valid,
    input  uop_t                         head_entry0,
    input  uop_t                         head_entry1,
    output logic                         mark0,
    output logic                         mark1,
    output logic [$clog2(ROB_DEPTH)-1:0] head,

    rob_write_if.ctrl                    wr
);

    localparam int PTR_W = $clog2(ROB_DEPTH);

    logic [PTR_W-1:0] tail;
    logic [PTR_W:0]   v_head;
    logic [PTR_W:0]   free_rows;
    logic             empty;
    logic             full;
    logic             dispatch_fire;
    logic             commit_fire;
    logic             good0;
    logic             good1;
    logic             done0;
    logic             done1;

    // head gets a wrap bit when the occupied span does not cross the end
    assign v_head    = {(tail >= head), head};
    assign free_rows = v_head - {1'b0, tail};

    assign empty = (head == tail);
    // one row always stays spare
    assign full  = (free_rows <= 1);

    assign dispatch_ready = !full;
    assign rob_empty      = empty;
    assign rob_full       = full;
    assign rob_id         = tail;
    assign dispatch_fire  = dispatch_valid && !full;

    // write port toward the banks
    assign wr.we    = dispatch_fire;
    assign wr.index = tail;
    assign wr.uop0  = dispatch_uop0;
    assign wr.uop1  = dispatch_uop1;

    // lane 0 waits for a delay slot in lane 1
    assign good0 = head_entry0.valid && !head_entry0.committed && !head_entry0.busy &&
                   (!head_entry1.is_ds || !head_entry1.busy);
    assign good1 = head_entry1.valid && !head_entry1.committed && !head_entry1.busy &&
                   done0;

    assign commit_valid = (good0 || good1) && !empty;
    assign commit_fire  = commit_valid && commit_ready;

    assign done0 = !head_entry0.valid || head_entry0.committed || (good0 && commit_fire);
    assign done1 = !head_entry1.valid || head_entry1.committed || (good1 && commit_fire);

    assign mark0 = commit_fire && good0;
    assign mark1 = commit_fire && good1;

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (dispatch_fire) begin
                tail <= tail + 1'b1;
            end
            // row retires once both lanes are out
            if (done0 && done1 && !empty) begin
                head <= head + 1'b1;
            end
        end
    end

endmodule

// ==== source/rob_report_router.sv ====
`timescale 1ns/1ns

module rob_report_router import rob_pkg::*; #(
    parameter int ROB_DEPTH = 16
) (
    input  fu_report_t   fu_report [NUM_FU],
    rob_update_if.router upd0,
    rob_update_if.router upd1
);

    localparam int PTR_W = $clog2(ROB_DEPTH);

    fu_report_t        masked [NUM_FU];
    logic [PTR_W-1:0]  row    [NUM_FU];
    logic [NUM_FU-1:0] lane;

    // id decode and capability masking
    always_comb begin
        for (int i = 0; i < NUM_FU; i++) begin
            lane[i] = fu_report[i].id[0];
            row[i]  = fu_report[i].id[PTR_W:1];

            masked[i] = fu_report[i];
            // mdu never carries branch or exception info
            if (!FU_CAN_BRANCH[i]) begin
                masked[i].set_branch = 1'b0;
            end
            if (!FU_CAN_EXC[i]) begin
                masked[i].set_exc = 1'b0;
            end
        end
    end

    // steer each finish to its lane
    always_comb begin
        for (int i = 0; i < NUM_FU; i++) begin
            upd0.en[i]     = fu_report[i].finish && !lane[i];
            upd0.index[i]  = row[i];
            upd0.report[i] = masked[i];

            upd1.en[i]     = fu_report[i].finish && lane[i];
            upd1.index[i]  = row[i];
            upd1.report[i] = masked[i];
        end
    end

endmodule

// ==== source/rob_slot_bank.sv ====
`timescale 1ns/1ns

module rob_slot_bank import rob_pkg::*; #(
    parameter int ROB_DEPTH = 16,
    parameter int LANE      = 0
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         flush,

    rob_write_if.bank                    wr,
    rob_update_if.bank                   upd,

    input  logic [$clog2(ROB_DEPTH)-1:0] head,
    input  logic                         mark,
    output uop_t                         head_entry
);

    localparam logic LANE_BIT = (LANE != 0);

    uop_t slots [ROB_DEPTH];
    uop_t wr_uop;

    // payload for this lane stamped with its own id
    always_comb begin
        wr_uop           = (LANE_BIT) ? wr.uop1 : wr.uop0;
        wr_uop.id        = ID_W_MAX'({wr.index, LANE_BIT});
        wr_uop.committed = 1'b0;
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            for (int r = 0; r < ROB_DEPTH; r++) begin
                slots[r] <= '0;
            end
        end else begin
            if (wr.we) begin
                slots[wr.index] <= wr_uop;
            end

            // completions in unit order where later units win on a clash
            for (int i = 0; i < NUM_FU; i++) begin
                if (upd.en[i]) begin
                    slots[upd.index[i]].busy <= 1'b0;
                    if (upd.report[i].set_branch) begin
                        slots[upd.index[i]].branch_taken <= upd.report[i].branch_taken;
                        slots[upd.index[i]].branch_addr  <= upd.report[i].branch_addr;
                    end
                    if (upd.report[i].set_exc) begin
                        slots[upd.index[i]].cause_exc <= 1'b1;
                        slots[upd.index[i]].exception <= upd.report[i].exc_code;
                    end
                end
            end

            // commit marking of the head row
            if (mark) begin
                slots[head].committed <= 1'b1;
            end
        end
    end

    // read port at head
    assign head_entry = slots[head];

endmodule

// ==== source/rob_top.sv ====
`timescale 1ns/1ns

module rob_top import rob_pkg::*; #(
    parameter int ROB_DEPTH = 16
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         flush,

    // dispatch
    input  logic                         dispatch_valid,
    input  uop_t                         dispatch_uop0,
    input  uop_t                         dispatch_uop1,
    output logic                         dispatch_ready,
    output logic [$clog2(ROB_DEPTH)-1:0] rob_id,
    output logic                         rob_empty,
    output logic                         rob_full,

    // completion
    input  fu_report_t                   fu_report [NUM_FU],

    // commit
    input  logic                         commit_ready,
    output logic                         commit_valid,
    output uop_t                         commit_uop0,
    output uop_t                         commit_uop1
);

    localparam int PTR_W = $clog2(ROB_DEPTH);

    logic [PTR_W-1:0] head;
    logic             mark0;
    logic             mark1;

    rob_write_if  #(.ROB_DEPTH(ROB_DEPTH)) wr_if   ();
    rob_update_if #(.ROB_DEPTH(ROB_DEPTH)) upd0_if ();
    rob_update_if #(.ROB_DEPTH(ROB_DEPTH)) upd1_if ();

    rob_ctrl #(.ROB_DEPTH(ROB_DEPTH)) ctrl0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush          (flush),
        .dispatch_valid (dispatch_valid),
        .dispatch_ready (dispatch_ready),
        .rob_id         (rob_id),
        .rob_empty      (rob_empty),
        .rob_full       (rob_full),
        .dispatch_uop0  (dispatch_uop0),
        .dispatch_uop1  (dispatch_uop1),
        .commit_ready   (commit_ready),
        .commit_valid   (commit_valid),
        .head_entry0    (commit_uop0),
        .head_entry1    (commit_uop1),
        .mark0          (mark0),
        .mark1          (mark1),
        .head           (head),
        .wr             (wr_if.ctrl)
    );

    rob_report_router #(.ROB_DEPTH(ROB_DEPTH)) router0 (
        .fu_report (fu_report),
        .upd0      (upd0_if.router),
        .upd1      (upd1_if.router)
    );

    // lane banks whose head rows go straight out as the commit pair
    rob_slot_bank #(.ROB_DEPTH(ROB_DEPTH), .LANE(0)) bank0 (
        .clk (clk), .rst_n (rst_n), .flush (flush),
        .wr (wr_if.bank), .upd (upd0_if.bank),
        .head (head), .mark (mark0), .head_entry (commit_uop0)
    );

    rob_slot_bank #(.ROB_DEPTH(ROB_DEPTH), .LANE(1)) bank1 (
        .clk (clk), .rst_n (rst_n), .flush (flush),
        .wr (wr_if.bank), .upd (upd1_if.bank),
        .head (head), .mark (mark1), .head_entry (commit_uop1)
    );

endmodule

// ==== bench/rob_tb_tasks.svh ====
`ifndef ROB_TB_TASKS_SVH
`define ROB_TB_TASKS_SVH

task automatic check_val(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
        $display("Error at %0t: %s expected %0h actual %0h", $time, name, expected, actual);
        errors++;
    end
endtask

// fresh busy micro-op with a wrong id that the bank must restamp
function automatic uop_t new_uop(input logic ds);
    uop_t u;
    u          = '0;
    u.valid    = 1'b1;
    u.busy     = 1'b1;
    u.is_ds    = ds;
    u.pc       = lcg_next() & 32'hffff_fffc;
    u.dest_reg = 6'(lcg_next() >> 8);
    u.id       = '1;
    return u;
endfunction

task automatic dispatch_pair(input uop_t u0, input uop_t u1);
    int n;
    n = 0;
    @(posedge clk);
    dispatch_valid <= 1'b1;
    dispatch_uop0  <= u0;
    dispatch_uop1  <= u1;
    @(negedge clk);
    while (!dispatch_ready && n < TIMEOUT) begin
        @(negedge clk);
        n++;
    end
    if (!dispatch_ready) begin
        $display("timeout at %0t: dispatch_ready never rose", $time);
        errors++;
    end else begin
        check_val("rob_id", exp_tail, rob_id);
        ref_row.push_back(exp_tail);
        ref_pc0.push_back(u0.pc);
        ref_pc1.push_back(u1.pc);
        exp_tail = exp_tail + 1'b1;
    end
    @(posedge clk);
    dispatch_valid <= 1'b0;
endtask

// one-cycle report that takes effect at the second edge
task automatic send_report(input int unit, input logic [PTR_W-1:0] row, input logic lane,
                           input logic set_br, input logic [31:0] addr,
                           input logic set_exc, input exc_code_t code);
    fu_report_t r;
    r              = '0;
    r.finish       = 1'b1;
    r.id           = ID_W_MAX'({row, lane});
    r.set_branch   = set_br;
    r.branch_taken = set_br;
    r.branch_addr  = addr;
    r.set_exc      = set_exc;
    r.exc_code     = code;
    @(posedge clk);
    fu_report[unit] <= r;
    @(posedge clk);
    fu_report[unit] <= '0;
endtask

task automatic finish_entry(input int unit, input logic [PTR_W-1:0] row, input logic lane);
    send_report(unit, row, lane, 1'b0, 32'h0, 1'b0, EXC_NONE);
endtask

task automatic set_commit_ready(input logic value);
    @(posedge clk);
    commit_ready <= value;
endtask

// returns on the falling edge where commit_valid is seen
task automatic wait_commit(output logic seen);
    int n;
    n = 0;
    @(negedge clk);
    while (!commit_valid && n < TIMEOUT) begin
        @(negedge clk);
        n++;
    end
    seen = commit_valid;
    if (!seen) begin
        $display("timeout at %0t: commit_valid never rose", $time);
        errors++;
    end
endtask

task automatic check_pair();
    logic [PTR_W-1:0] row;
    if (ref_row.size() == 0) begin
        $display("commit at %0t with no dispatched pair outstanding", $time);
        errors++;
    end else begin
        row = ref_row.pop_front();
        check_val("commit_uop0.valid", 1, commit_uop0.valid);
        check_val("commit_uop1.valid", 1, commit_uop1.valid);
        check_val("commit_uop0.pc", ref_pc0.pop_front(), commit_uop0.pc);
        check_val("commit_uop1.pc", ref_pc1.pop_front(), commit_uop1.pc);
        check_val("commit_uop0.id", {row, 1'b0}, commit_uop0.id);
        check_val("commit_uop1.id", {row, 1'b1}, commit_uop1.id);
        check_val("commit_uop0.committed", 0, commit_uop0.committed);
        check_val("commit_uop1.committed", 0, commit_uop1.committed);
    end
endtask

// commit_ready must already be high
task automatic retire_pair();
    logic seen;
    wait_commit(seen);
    if (seen) begin
        check_pair();
    end
    @(posedge clk);
endtask

task automatic check_idle();
    check_val("rob_empty", 1, rob_empty);
    check_val("dispatch_ready", 1, dispatch_ready);
    check_val("commit_valid", 0, commit_valid);
    check_val("rob_id", 0, rob_id);
endtask

task automatic check_reset_state();
    @(negedge clk);
    check_idle();
endtask

task automatic retire_in_order();
    int order [10];
    int j;
    int tmp;
    for (int p = 0; p < 5; p++) begin
        dispatch_pair(new_uop(1'b0), new_uop(1'b0));
    end
    for (int k = 0; k < 10; k++) begin
        order[k] = k;
    end
    // shuffle the finish order
    for (int i = 9; i > 0; i--) begin
        j        = int'(lcg_next() % (i + 1));
        tmp      = order[i];
        order[i] = order[j];
        order[j] = tmp;
    end
    for (int k = 0; k < 10; k++) begin
        finish_entry(int'(lcg_next() % NUM_FU), ref_row[order[k] / 2], order[k] % 2 != 0);
    end
    set_commit_ready(1'b1);
    for (int p = 0; p < 5; p++) begin
        retire_pair();
    end
    set_commit_ready(1'b0);
    @(negedge clk);
    check_val("rob_empty", 1, rob_empty);
endtask

task automatic fill_and_drain();
    int rows_in;
    rows_in = 0;
    @(negedge clk);
    while (dispatch_ready && rows_in <= DEPTH) begin
        dispatch_pair(new_uop(1'b0), new_uop(1'b0));
        rows_in++;
        @(negedge clk);
    end
    check_val("dispatched rows", DEPTH - 1, rows_in);
    check_val("rob_full", 1, rob_full);
    check_val("dispatch_ready", 0, dispatch_ready);
    for (int k = 0; k < 2 * rows_in; k++) begin
        finish_entry(int'(lcg_next() % NUM_FU), ref_row[k / 2], k % 2 != 0);
    end
    // all finished but held while commit_ready is low
    @(negedge clk);
    check_val("commit_valid", 1, commit_valid);
    check_val("rob_full", 1, rob_full);
    set_commit_ready(1'b1);
    for (int p = 0; p < rows_in; p++) begin
        retire_pair();
    end
    set_commit_ready(1'b0);
    @(negedge clk);
    check_val("rob_empty", 1, rob_empty);
endtask

task automatic delay_slot_hold();
    logic             seen;
    logic [PTR_W-1:0] row;
    set_commit_ready(1'b1);
    dispatch_pair(new_uop(1'b0), new_uop(1'b1));
    row = ref_row[0];
    finish_entry(0, row, 1'b0);
    // lane 0 done but held by the busy delay slot
    repeat (4) begin
        @(negedge clk);
        check_val("commit_valid", 0, commit_valid);
    end
    finish_entry(1, row, 1'b1);
    retire_pair();
    @(negedge clk);
    check_val("rob_empty", 1, rob_empty);

    // plain pair with lane 1 late
    dispatch_pair(new_uop(1'b0), new_uop(1'b0));
    row = ref_row[0];
    finish_entry(2, row, 1'b0);
    wait_commit(seen);
    check_val("commit_uop0.pc", ref_pc0[0], commit_uop0.pc);
    check_val("commit_uop0.committed", 0, commit_uop0.committed);
    check_val("commit_uop1.busy", 1, commit_uop1.busy);
    @(posedge clk);
    @(negedge clk);
    check_val("commit_valid", 0, commit_valid);
    check_val("rob_empty", 0, rob_empty);
    finish_entry(3, row, 1'b1);
    wait_commit(seen);
    check_val("commit_uop0.committed", 1, commit_uop0.committed);
    check_val("commit_uop1.pc", ref_pc1[0], commit_uop1.pc);
    check_val("commit_uop1.id", {row, 1'b1}, commit_uop1.id);
    @(posedge clk);
    void'(ref_row.pop_front());
    void'(ref_pc0.pop_front());
    void'(ref_pc1.pop_front());
    set_commit_ready(1'b0);
    @(negedge clk);
    check_val("rob_empty", 1, rob_empty);
endtask

task automatic branch_exc_capture();
    logic             seen;
    logic [31:0]      addr;
    logic [PTR_W-1:0] row;
    addr = lcg_next() & 32'hffff_fffc;
    dispatch_pair(new_uop(1'b0), new_uop(1'b0));
    row = ref_row[0];
    send_report(1, row, 1'b0, 1'b1, addr, 1'b0, EXC_NONE);
    send_report(3, row, 1'b1, 1'b0, 32'h0, 1'b1, EXC_ADEL);
    // mdu cannot raise exceptions so this one must not land
    send_report(2, row, 1'b1, 1'b0, 32'h0, 1'b1, EXC_OV);
    set_commit_ready(1'b1);
    wait_commit(seen);
    check_val("commit_uop0.branch_taken", 1, commit_uop0.branch_taken);
    check_val("commit_uop0.branch_addr", addr, commit_uop0.branch_addr);
    check_val("commit_uop0.cause_exc", 0, commit_uop0.cause_exc);
    check_val("commit_uop0.exception", EXC_NONE, commit_uop0.exception);
    check_val("commit_uop1.branch_taken", 0, commit_uop1.branch_taken);
    check_val("commit_uop1.cause_exc", 1, commit_uop1.cause_exc);
    check_val("commit_uop1.exception", EXC_ADEL, commit_uop1.exception);
    check_pair();
    @(posedge clk);
    set_commit_ready(1'b0);
    @(negedge clk);
    check_val("rob_empty", 1, rob_empty);
endtask

task automatic flush_clears();
    for (int p = 0; p < 3; p++) begin
        dispatch_pair(new_uop(1'b0), new_uop(1'b0));
    end
    @(posedge clk);
    flush <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
    ref_row.delete();
    ref_pc0.delete();
    ref_pc1.delete();
    exp_tail = '0;
    @(negedge clk);
    check_idle();
    dispatch_pair(new_uop(1'b0), new_uop(1'b0));
    @(negedge clk);
    check_val("rob_id", 1, rob_id);
    check_val("commit_uop0.id", 0, commit_uop0.id);
endtask

`endif

// ==== bench/rob_tb.sv ====
`timescale 1ns/1ns

module rob_tb import rob_pkg::*; ();

    localparam int DEPTH        = 8;
    localparam int PTR_W        = $clog2(DEPTH);
    localparam int PERIOD       = 100;
    localparam int RESET_CYCLES = 10;
    localparam int TIMEOUT      = 200;
    localparam logic [31:0] SEED = 32'h2745;

    logic             clk = 1'b0;
    logic             rst_n;
    logic             flush;
    logic             dispatch_valid;
    uop_t             dispatch_uop0;
    uop_t             dispatch_uop1;
    logic             dispatch_ready;
    logic [PTR_W-1:0] rob_id;
    logic             rob_empty;
    logic             rob_full;
    fu_report_t       fu_report [NUM_FU];
    logic             commit_ready;
    logic             commit_valid;
    uop_t             commit_uop0;
    uop_t             commit_uop1;

    // dispatched pairs still waiting to retire
    logic [PTR_W-1:0] ref_row [$];
    logic [31:0]      ref_pc0 [$];
    logic [31:0]      ref_pc1 [$];

    // expected tail, one step per accepted dispatch
    logic [PTR_W-1:0] exp_tail = '0;

    int          checks = 0;
    int          errors = 0;
    int          err_before;
    logic [31:0] lcg_state = SEED;

    rob_top #(.ROB_DEPTH(DEPTH)) dut0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush          (flush),
        .dispatch_valid (dispatch_valid),
        .dispatch_uop0  (dispatch_uop0),
        .dispatch_uop1  (dispatch_uop1),
        .dispatch_ready (dispatch_ready),
        .rob_id         (rob_id),
        .rob_empty      (rob_empty),
        .rob_full       (rob_full),
        .fu_report      (fu_report),
        .commit_ready   (commit_ready),
        .commit_valid   (commit_valid),
        .commit_uop0    (commit_uop0),
        .commit_uop1    (commit_uop1)
    );

    always #(PERIOD / 2) clk = ~clk;

    // linear congruential generator
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    `include "rob_tb_tasks.svh"

    task automatic report_test(input string name, input int err_start);
        if (errors == err_start) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - err_start);
        end
    endtask

    initial begin
        rst_n          <= 1'b0;
        flush          <= 1'b0;
        dispatch_valid <= 1'b0;
        dispatch_uop0  <= '0;
        dispatch_uop1  <= '0;
        commit_ready   <= 1'b0;
        for (int i = 0; i < NUM_FU; i++) begin
            fu_report[i] <= '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        err_before = errors;
        check_reset_state();
        report_test("reset state", err_before);

        err_before = errors;
        retire_in_order();
        report_test("in-order retirement", err_before);

        err_before = errors;
        fill_and_drain();
        report_test("fill and back-pressure", err_before);

        err_before = errors;
        delay_slot_hold();
        report_test("delay slot and split commit", err_before);

        err_before = errors;
        branch_exc_capture();
        report_test("branch and exception capture", err_before);

        err_before = errors;
        flush_clears();
        report_test("flush", err_before);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== rob_core.f ====
+incdir+bench
source/rob_pkg.sv
source/rob_ifs.sv
source/rob_ctrl.sv
source/rob_report_router.sv
source/rob_slot_bank.sv
source/rob_top.sv
bench/rob_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the reorder buffer testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module rob_tb -f rob_core.f -o rob_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/rob_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
    exit 1
fi

if ! grep -q "RESULT: PASS" "$LOG"; then
    echo "simulation ended without a result line"
    exit 1
fi

exit 0
